// File: rv_defines.svh
//////////////////////////////
// sizes for the single-cycle core. Only XLEN of 32 is supported.
//////////////////////////////
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path and address width in bits.
`define XLEN 32

// architectural register count, x0 included.
`define NREGS 32

// data memory depth in words. Addresses wrap at this size.
`define DMEM_WORDS 256

// first fetch address after reset.
`define RESET_PC 32'h0000_0000

`endif

// File: rv_pkg.sv
//////////////////////////////
// shared types for the RV32I core. Only base integer opcodes are listed.
//////////////////////////////
`include "rv_defines.svh"

package rv_pkg;

	typedef enum logic [6:0] {
		RTYPE = 7'b0110011,
		ITYPE = 7'b0010011,
		LTYPE = 7'b0000011,
		STYPE = 7'b0100011,
		BTYPE = 7'b1100011,
		JALR  = 7'b1100111,
		JAL   = 7'b1101111,
		AUIPC = 7'b0010111,
		LUI   = 7'b0110111
	} opcode_e;

	// ADD must stay at zero so that a cleared control word is a harmless add.
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		SLL  = 4'd2,
		SLT  = 4'd3,
		SLTU = 4'd4,
		XOR  = 4'd5,
		SRL  = 4'd6,
		SRA  = 4'd7,
		OR   = 4'd8,
		AND  = 4'd9
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_PC4 = 2'd2,  // link address for the jumps.
		WB_IMM = 2'd3   // LUI writes the immediate directly.
	} wb_sel_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one fetched word, seen through each RV32I encoding.
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

	typedef struct packed {
		alu_op_e          alu_op;
		logic             alu_src_imm;  // second operand is the immediate.
		logic [`XLEN-1:0] imm;
		logic             reg_write;
		logic             mem_read;
		logic             mem_write;
		logic [2:0]       funct3;       // width and signedness for memory, condition for branches.
		logic             is_branch;
		logic             is_jal;
		logic             is_jalr;
		wb_sel_e          wb_sel;
		logic             use_pc_a;     // first operand is the pc, as for AUIPC.
	} ctrl_t;

endpackage

// File: rv_alu.sv
//////////////////////////////
// combinational ALU and branch compare. Shifts use the low five bits.
//////////////////////////////
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_alu (
	input  rv_pkg::ctrl_t    ctrl,
	input  logic [`XLEN-1:0] pc,
	input  logic [`XLEN-1:0] rv1,
	input  logic [`XLEN-1:0] rv2,
	output logic [`XLEN-1:0] alu_res,
	output logic             br_taken
);
	import rv_pkg::*;

	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [4:0]       shamt;
	logic             cond;

	assign op_a  = ctrl.use_pc_a ? pc : rv1;
	assign op_b  = ctrl.alu_src_imm ? ctrl.imm : rv2;
	assign shamt = op_b[4:0];

	always_comb begin
		alu_res = '0;
		case (ctrl.alu_op)
			ADD:  alu_res = op_a + op_b;  // also the load and store address.
			SUB:  alu_res = op_a - op_b;
			SLL:  alu_res = op_a << shamt;
			SLT:  alu_res[0] = $signed(op_a) < $signed(op_b);
			SLTU: alu_res[0] = op_a < op_b;
			XOR:  alu_res = op_a ^ op_b;
			SRL:  alu_res = op_a >> shamt;
			SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
			OR:   alu_res = op_a | op_b;
			AND:  alu_res = op_a & op_b;
			default: alu_res = '0;
		endcase
	end

	// branches compare the two registers, never the immediate.
	always_comb begin
		case (ctrl.funct3)
			3'b000:  cond = (rv1 == rv2);
			3'b001:  cond = (rv1 != rv2);
			3'b100:  cond = $signed(rv1) < $signed(rv2);
			3'b101:  cond = $signed(rv1) >= $signed(rv2);
			3'b110:  cond = rv1 < rv2;
			3'b111:  cond = rv1 >= rv2;
			default: cond = 1'b0;  // 010 and 011 are not branch encodings.
		endcase
	end

	assign br_taken = ctrl.is_branch && cond;

endmodule

// File: rv_regfile.sv
//////////////////////////////
// 32 x 32 register file. Reads are combinational, x0 reads as zero.
//////////////////////////////
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
	input  logic             instr,
	input  logic             reset,
	input  logic [4:0]       rs1,
	input  logic [4:0]       rs2,
	input  logic [4:0]       rd,
	input  logic [`XLEN-1:0] wr_data,
	input  logic             we,
	output logic [`XLEN-1:0] rv1,
	output logic [`XLEN-1:0] rv2,
	output logic [`XLEN-1:0] x31
);
	logic [`XLEN-1:0] regs [`NREGS];

	always_ff @(posedge instr) begin
		if (reset) begin
			for (int i = 0; i < `NREGS; i++)
				regs[i] <= '0;
		end else if (we && rd != 5'd0) begin  // writes to x0 are dropped.
			regs[rd] <= wr_data;
		end
	end

	// x0 stays zero because reset clears it and no write reaches it.
	assign rv1 = regs[rs1];
	assign rv2 = regs[rs2];

	// the last register is the observation port of the core.
	assign x31 = regs[`NREGS-1];

endmodule

// File: rv_lsu.sv
//////////////////////////////
// data memory without reset. Misaligned accesses are not detected.
//////////////////////////////
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_lsu (
	input  logic             instr,
	input  logic             reset,
	input  rv_pkg::ctrl_t    ctrl,
	input  logic [`XLEN-1:0] addr,
	input  logic [`XLEN-1:0] rv2,
	output logic [`XLEN-1:0] load_data
);
	logic [`XLEN-1:0]               dmem [`DMEM_WORDS];
	logic [$clog2(`DMEM_WORDS)-1:0] word_idx;
	logic [1:0]                     lane;
	logic [3:0]                     byte_en;
	logic [`XLEN-1:0]               st_data;
	logic [`XLEN-1:0]               rd_word;
	logic [7:0]                     ld_byte;
	logic [15:0]                    ld_half;
	logic [`XLEN-1:0]               ld_ext;

	// upper address bits are ignored, so the array wraps.
	assign word_idx = addr[$clog2(`DMEM_WORDS)+1:2];
	assign lane     = addr[1:0];

	// the value is copied to every lane and the enables pick the addressed ones.
	always_comb begin
		case (ctrl.funct3[1:0])
			2'b00: begin
				st_data = {4{rv2[7:0]}};
				byte_en = 4'b0001 << lane;
			end
			2'b01: begin
				st_data = {2{rv2[15:0]}};
				byte_en = lane[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				st_data = rv2;
				byte_en = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge instr) begin
		if (!reset && ctrl.mem_write) begin
			for (int b = 0; b < 4; b++) begin
				if (byte_en[b])
					dmem[word_idx][8*b +: 8] <= st_data[8*b +: 8];
			end
		end
	end

	assign rd_word = dmem[word_idx];
	assign ld_byte = rd_word[{lane, 3'b000} +: 8];
	assign ld_half = lane[1] ? rd_word[31:16] : rd_word[15:0];

	always_comb begin
		case (ctrl.funct3)
			3'b000:  ld_ext = {{24{ld_byte[7]}}, ld_byte};   // LB.
			3'b001:  ld_ext = {{16{ld_half[15]}}, ld_half};  // LH.
			3'b100:  ld_ext = {24'b0, ld_byte};
			3'b101:  ld_ext = {16'b0, ld_half};
			default: ld_ext = rd_word;
		endcase
	end

	assign load_data = ctrl.mem_read ? ld_ext : '0;

endmodule

// File: rv_control.sv
//////////////////////////////
// decode and pc for one instruction per cycle. idata must hold for the cycle.
// unknown opcodes write nothing and fall through to pc plus four.
//////////////////////////////
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_control (
	input  logic             instr,
	input  logic             reset,
	input  rv_pkg::instr_u   idata,
	input  logic [`XLEN-1:0] alu_res,
	input  logic             br_taken,
	input  logic [`XLEN-1:0] rv1,
	input  logic [`XLEN-1:0] load_data,
	output logic [`XLEN-1:0] iaddr,
	output rv_pkg::ctrl_t    ctrl,
	output logic [4:0]       rs1,
	output logic [4:0]       rs2,
	output logic [4:0]       rd,
	output logic [`XLEN-1:0] wr_data
);
	import rv_pkg::*;

	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] pc_rel;
	logic [`XLEN-1:0] jalr_sum;
	logic [`XLEN-1:0] pc_next;

	// alt is funct7 bit 5. It selects SRA over SRL, and SUB over ADD only for R-type.
	function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt,
			input logic is_reg);
		alu_op_e op;
		case (funct3)
			3'b000:  op = (alt && is_reg) ? SUB : ADD;
			3'b001:  op = SLL;
			3'b010:  op = SLT;
			3'b011:  op = SLTU;
			3'b100:  op = XOR;
			3'b101:  op = alt ? SRA : SRL;
			3'b110:  op = OR;
			default: op = AND;
		endcase
		return op;
	endfunction

	// register fields sit in the same place in every format that has them.
	assign rs1 = idata.r.rs1;
	assign rs2 = idata.r.rs2;
	assign rd  = idata.r.rd;

	always_comb begin
		ctrl        = '0;  // no writes and a plain add unless the opcode says otherwise.
		ctrl.funct3 = idata.r.funct3;
		case (opcode_e'(idata.r.opcode))
			RTYPE: begin
				ctrl.alu_op    = alu_decode(idata.r.funct3, idata.r.funct7[5], 1'b1);
				ctrl.reg_write = 1'b1;
			end
			ITYPE: begin
				ctrl.imm         = {{20{idata.i.imm[11]}}, idata.i.imm};
				ctrl.alu_op      = alu_decode(idata.i.funct3, idata.i.imm[10], 1'b0);
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write   = 1'b1;
			end
			LTYPE: begin
				ctrl.imm         = {{20{idata.i.imm[11]}}, idata.i.imm};
				ctrl.alu_src_imm = 1'b1;   // the ALU forms the address.
				ctrl.reg_write   = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.wb_sel      = WB_MEM;
			end
			STYPE: begin
				ctrl.imm         = {{20{idata.s.imm_hi[6]}}, idata.s.imm_hi, idata.s.imm_lo};
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
			end
			BTYPE: begin
				ctrl.imm       = {{19{idata.b.imm_12}}, idata.b.imm_12, idata.b.imm_11,
					idata.b.imm_10_5, idata.b.imm_4_1, 1'b0};
				ctrl.alu_op    = SUB;
				ctrl.is_branch = 1'b1;
			end
			JALR: begin
				ctrl.imm       = {{20{idata.i.imm[11]}}, idata.i.imm};
				ctrl.reg_write = 1'b1;
				ctrl.is_jalr   = 1'b1;
				ctrl.wb_sel    = WB_PC4;
			end
			JAL: begin
				ctrl.imm       = {{11{idata.j.imm_20}}, idata.j.imm_20, idata.j.imm_19_12,
					idata.j.imm_11, idata.j.imm_10_1, 1'b0};
				ctrl.reg_write = 1'b1;
				ctrl.is_jal    = 1'b1;
				ctrl.wb_sel    = WB_PC4;
			end
			AUIPC: begin
				ctrl.imm         = {idata.u.imm, 12'b0};
				ctrl.alu_src_imm = 1'b1;
				ctrl.use_pc_a    = 1'b1;
				ctrl.reg_write   = 1'b1;
			end
			LUI: begin
				ctrl.imm       = {idata.u.imm, 12'b0};
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_IMM;
			end
			default: ;
		endcase
	end

	assign pc_plus4 = iaddr + `XLEN'd4;
	assign pc_rel   = iaddr + ctrl.imm;   // shared by taken branches and JAL.
	assign jalr_sum = rv1 + ctrl.imm;

	always_comb begin
		if (ctrl.is_jalr)
			pc_next = {jalr_sum[`XLEN-1:1], 1'b0};
		else if (ctrl.is_jal || br_taken)
			pc_next = pc_rel;
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge instr) begin
		if (reset)
			iaddr <= `RESET_PC;
		else
			iaddr <= pc_next;
	end

	always_comb begin
		case (ctrl.wb_sel)
			WB_MEM:  wr_data = load_data;
			WB_PC4:  wr_data = pc_plus4;
			WB_IMM:  wr_data = ctrl.imm;
			default: wr_data = alu_res;
		endcase
	end

endmodule

// File: rv_core.sv
//////////////////////////////
// single-cycle RV32I top. idata must follow iaddr within the same cycle.
//////////////////////////////
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core (
	input  logic             instr,
	input  logic             reset,
	input  logic [`XLEN-1:0] idata,
	output logic [`XLEN-1:0] iaddr,
	output logic [`XLEN-1:0] x31
);
	import rv_pkg::*;

	ctrl_t            ctrl;
	logic [4:0]       rs1;
	logic [4:0]       rs2;
	logic [4:0]       rd;
	logic [`XLEN-1:0] rv1;
	logic [`XLEN-1:0] rv2;
	logic [`XLEN-1:0] alu_res;
	logic [`XLEN-1:0] load_data;
	logic [`XLEN-1:0] wr_data;
	logic             br_taken;

	rv_control ctrl0 (
		.instr, .reset, .idata,
		.alu_res, .br_taken, .rv1, .load_data,
		.iaddr, .ctrl, .rs1, .rs2, .rd, .wr_data
	);

	// the pc feeds the ALU for AUIPC.
	rv_alu alu0 (
		.ctrl, .pc(iaddr), .rv1, .rv2,
		.alu_res, .br_taken
	);

	rv_regfile rf0 (
		.instr, .reset, .rs1, .rs2, .rd,
		.wr_data, .we(ctrl.reg_write),
		.rv1, .rv2, .x31
	);

	rv_lsu lsu0 (
		.instr, .reset, .ctrl,
		.addr(alu_res), .rv2,
		.load_data
	);

endmodule

// File: rv_core_props.sv
//////////////////////////////
// fetch address checks, bound into rv_core.
//////////////////////////////
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core_props (
	input logic             instr,
	input logic             reset,
	input logic [`XLEN-1:0] iaddr
);

	// every fetch lands on a word boundary.
	iaddr_aligned: assert property (@(posedge instr) disable iff (reset)
		iaddr[1:0] == 2'b00)
		else $error("iaddr %h is not word aligned", iaddr);

	// a reset edge always restarts the fetch.
	iaddr_after_reset: assert property (@(posedge instr)
		reset |=> iaddr == `RESET_PC)
		else $error("iaddr %h after reset differs from the reset pc", iaddr);

	iaddr_known: assert property (@(posedge instr) disable iff (reset)
		!$isunknown(iaddr))
		else $error("iaddr holds unknown bits");

endmodule

bind rv_core rv_core_props props0 (
	.instr(instr),
	.reset(reset),
	.iaddr(iaddr)
);

// File: rv_core_tb.sv
//////////////////////////////
// runs program_input.txt on the core. Check lines must be in cycle order.
//////////////////////////////
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core_tb;

	localparam int IMEM_WORDS  = 256;
	localparam int CYCLE_LIMIT = 2000;
	localparam int LINE_LIMIT  = 1000;

	logic             instr;
	logic             reset;
	logic [`XLEN-1:0] idata;
	logic [`XLEN-1:0] iaddr;
	logic [`XLEN-1:0] x31;
	logic [`XLEN-1:0] imem [IMEM_WORDS];
	int               check_cycle [$];
	logic [`XLEN-1:0] check_value [$];
	int               cycle;
	int               errors;
	int               tests;
	int               failed_tests;

	rv_core dut0 (.instr, .reset, .idata, .iaddr, .x31);

	initial begin
		instr = 1'b0;
		forever #50 instr = ~instr;
	end

	// instruction memory answers within the cycle.
	always_comb idata = $isunknown(iaddr) ? '0 : imem[iaddr[9:2]];

	task automatic compare_value(input string sig, input logic [`XLEN-1:0] expected,
			input logic [`XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h actual %h", sig, expected, actual);
			errors++;
		end
	endtask

	task automatic load_program();
		int               fd;
		int               code;
		int               guard;
		int               c;
		string            tag;
		string            rest;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] w;
		fd = $fopen("program_input.txt", "r");
		if (fd == 0) begin
			$display("could not open program_input.txt");
			errors++;
			return;
		end
		guard = 0;
		while (!$feof(fd) && guard < LINE_LIMIT) begin
			guard++;
			code = $fscanf(fd, " %s", tag);
			if (code != 1)
				break;
			if (tag == "p") begin
				code = $fscanf(fd, " %h %h", a, w);
				imem[a[7:0]] = w;
			end else if (tag == "c") begin
				code = $fscanf(fd, " %d %h", c, w);
				check_cycle.push_back(c);
				check_value.push_back(w);
			end else begin
				code = $fgets(rest, fd);  // comment text up to the end of the line.
			end
		end
		$fclose(fd);
		if (guard >= LINE_LIMIT) begin
			$display("program_input.txt has more lines than expected");
			errors++;
		end
	endtask

	// reset is sampled high on eight edges; cycle 1 is the first executing edge.
	task automatic apply_reset();
		@(posedge instr);
		reset <= 1'b1;
		repeat (8) @(posedge instr);
		reset <= 1'b0;
		cycle = 0;
	endtask

	task automatic wait_until_cycle(input int target, output bit ok);
		int guard;
		guard = 0;
		ok = 1'b1;
		while (cycle < target) begin
			if (guard >= CYCLE_LIMIT) begin
				ok = 1'b0;
				return;
			end
			@(posedge instr);
			cycle++;
			guard++;
		end
	endtask

	initial begin
		int errors_before;
		bit ok;
		reset = 1'b1;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		cycle = 0;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = '0;
		load_program();
		if (check_cycle.size() == 0) begin
			$display("no checks were loaded");
			errors++;
		end
		apply_reset();
		for (int i = 0; i < check_cycle.size(); i++) begin
			wait_until_cycle(check_cycle[i], ok);
			if (!ok) begin
				$display("timed out waiting for cycle %0d", check_cycle[i]);
				errors++;
				break;
			end
			@(negedge instr);  // outputs have settled after the edge.
			errors_before = errors;
			compare_value("x31", check_value[i], x31);
			tests++;
			if (errors != errors_before)
				failed_tests++;
			$display("test %0d cycle %0d x31: %s", tests, check_cycle[i],
				(errors == errors_before) ? "ok" : "mismatch");
		end
		// a second reset must restart the fetch and clear x31.
		apply_reset();
		@(negedge instr);
		errors_before = errors;
		compare_value("iaddr", `RESET_PC, iaddr);
		compare_value("x31", '0, x31);
		tests++;
		if (errors != errors_before)
			failed_tests++;
		$display("test %0d second reset: %s", tests,
			(errors == errors_before) ? "ok" : "mismatch");
		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: compile.f
+incdir+.
rv_pkg.sv
rv_alu.sv
rv_regfile.sv
rv_lsu.sv
rv_control.sv
rv_core.sv
rv_core_props.sv
rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= compile.f

SRCS := $(filter %.sv,$(shell cat $(FILELIST)))
HDRS := rv_defines.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)

// File: program_input.txt
# p word_address instruction   (hex, word address is iaddr / 4)
# c cycle_after_reset expected_x31   (decimal cycle, hex value)
p 00 123450B7 # lui x1, 0x12345
p 01 67808F93 # addi x31, x1, 0x678
p 02 FF800113 # addi x2, x0, -8
p 03 002F8FB3 # add x31, x31, x2
p 04 40110FB3 # sub x31, x2, x1
p 05 40215F93 # srai x31, x2, 2
p 06 00415F93 # srli x31, x2, 4
p 07 00409F93 # slli x31, x1, 4
p 08 00112FB3 # slt x31, x2, x1
p 09 00113FB3 # sltu x31, x2, x1
p 0A 0FF0CF93 # xori x31, x1, 0xff
p 0B 0020EFB3 # or x31, x1, x2
p 0C 0020FFB3 # and x31, x1, x2
p 0D 00102823 # sw x1, 16(x0)
p 0E 002008A3 # sb x2, 17(x0)
p 0F 01002F83 # lw x31, 16(x0)
p 10 01100F83 # lb x31, 17(x0)
p 11 01104F83 # lbu x31, 17(x0)
p 12 00201923 # sh x2, 18(x0)
p 13 01201F83 # lh x31, 18(x0)
p 14 01205F83 # lhu x31, 18(x0)
p 15 01001F83 # lh x31, 16(x0)
p 16 00000F93 # addi x31, x0, 0
p 17 00208463 # beq x1, x2, +8 not taken
p 18 001F8F93 # addi x31, x31, 1
p 19 00209463 # bne x1, x2, +8 taken
p 1A 100F8F93 # addi x31, x31, 0x100 skipped
p 1B 00114463 # blt x2, x1, +8 taken
p 1C 100F8F93 # skipped
p 1D 00115463 # bge x2, x1, +8 not taken
p 1E 002F8F93 # addi x31, x31, 2
p 1F 00116463 # bltu x2, x1, +8 not taken
p 20 004F8F93 # addi x31, x31, 4
p 21 00117463 # bgeu x2, x1, +8 taken
p 22 100F8F93 # skipped
p 23 008F8F93 # addi x31, x31, 8
p 24 00800FEF # jal x31, +8
p 25 100F8F93 # skipped
p 26 00001F97 # auipc x31, 0x1
p 27 0A800193 # addi x3, x0, 0xa8
p 28 00118FE7 # jalr x31, 1(x3)
p 29 100F8F93 # skipped
p 2A 05500013 # addi x0, x0, 0x55
p 2B 00000FB3 # add x31, x0, x0
p 2C 07700F93 # addi x31, x0, 0x77
p 2D 0000006F # jal x0, 0
c 2 12345678
c 4 12345670
c 5 EDCBAFF8
c 6 FFFFFFFE
c 7 0FFFFFFF
c 8 23450000
c 9 00000001
c 10 00000000
c 11 123450FF
c 12 FFFFFFF8
c 13 12345000
c 16 1234F800
c 17 FFFFFFF8
c 18 000000F8
c 20 FFFFFFF8
c 21 0000FFF8
c 22 FFFFF800
c 25 00000001
c 31 00000007
c 33 0000000F
c 34 00000094
c 35 00001098
c 37 000000A4
c 38 000000A4
c 39 00000000
c 40 00000077
